/* filelist.f */
logic/fetch_pkg.sv
logic/mem_bus_pkg.sv
logic/fetch_pc_gen.sv
logic/icache_way.sv
logic/icache_refill_ctrl.sv
logic/if_stage.sv
testbench/tb_mem_model.sv
testbench/tb_if_stage.sv

/* logic/fetch_pc_gen.sv */
`timescale 1ns/10ps

module fetch_pc_gen
  import fetch_pkg::*;
#(
  parameter addr_t BOOT_PC = 64'h0000_0000_8000_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  redirect_valid_i,
  input  addr_t redirect_pc_i,
  input  logic  req_ready_i,
  output logic  req_valid_o,
  output addr_t req_pc_o
);

  addr_t pc_q;
  addr_t pc_next;
  logic  req_fire;

  // the cycle of a redirect never issues, the old-path pc is stale
  assign req_valid_o = !redirect_valid_i;
  assign req_fire    = req_valid_o && req_ready_i;
  assign req_pc_o    = pc_q;

  // redirect wins over sequential advance
  always_comb begin
    pc_next = pc_q;
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;
    end else if (req_fire) begin
      pc_next = pc_q + FETCH_STEP;  // no prediction, just pc + 4
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  // targets from later stages must be word aligned as well
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc_q[1:0] == 2'b00)
    else $error("fetch pc %h not 4-byte aligned", pc_q);

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

  // byte address as seen by the core
  typedef logic [63:0] addr_t;

  // one uncompressed instruction word
  typedef logic [31:0] inst_t;

  // addi x0, x0, 0
  localparam inst_t NOP_INST = 32'h0000_0013;

  // sequential fetch offset, no compressed instructions
  localparam addr_t FETCH_STEP = 64'd4;

endpackage

/* logic/icache_refill_ctrl.sv */
`timescale 1ns/10ps

module icache_refill_ctrl
  import fetch_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter  int NUM_WAYS = 2,
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = 64 - LINE_OFF_W - IDX_W
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid_i,
  input  addr_t               req_pc_i,
  output logic                req_ready_o,
  output logic                lookup_en_o,
  input  logic [NUM_WAYS-1:0] hit_i,
  input  inst_t               rdata_i [NUM_WAYS],
  output logic [NUM_WAYS-1:0] fill_we_o,
  output logic [IDX_W-1:0]    fill_index_o,
  output logic [TAG_W-1:0]    fill_tag_o,
  output beat_t               fill_beat_o,
  output bus_data_t           fill_data_o,
  input  logic                redirect_valid_i,
  output logic                inst_valid_o,
  input  logic                inst_ready_i,
  output inst_t               inst_o,
  output addr_t               inst_pc_o,
  output logic                mem_ar_valid_o,
  input  logic                mem_ar_ready_i,
  output addr_t               mem_ar_addr_o,
  input  logic                mem_r_valid_i,
  output logic                mem_r_ready_o,
  input  bus_data_t           mem_r_data_i,
  input  resp_t               mem_r_resp_i,
  input  logic                mem_r_last_i
);

  localparam int VW = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  refill_state_t state_q, state_d;

  addr_t         look_pc_q;           // pc of the request in flight
  beat_t         beat_q;
  logic          drop_q;              // redirected while the burst runs
  logic [VW-1:0] victim_q [NUM_SETS]; // round-robin pointer per set
  inst_t         miss_inst_q;

  logic  any_hit;
  inst_t hit_word;
  logic  out_fire;
  logic  fill_fire;
  logic  fill_done;
  beat_t want_beat;

  assign any_hit = |hit_i;

  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_i[w]) begin
        hit_word = hit_word | rdata_i[w];
      end
    end
  end

  // hits are presented straight out of the lookup cycle
  assign inst_valid_o = ((state_q == LOOKUP && any_hit) || state_q == DELIVER)
                        && !redirect_valid_i;
  assign inst_o       = !inst_valid_o        ? NOP_INST :
                        (state_q == DELIVER) ? miss_inst_q : hit_word;
  assign inst_pc_o    = look_pc_q;
  assign out_fire     = inst_valid_o && inst_ready_i;

  // second item may enter while the first one leaves
  assign req_ready_o = (state_q == IDLE) || out_fire;
  assign lookup_en_o = req_valid_i && req_ready_o;

  assign fill_index_o = look_pc_q[LINE_OFF_W +: IDX_W];
  assign fill_tag_o   = look_pc_q[63 -: TAG_W];
  assign want_beat    = look_pc_q[LINE_OFF_W-1:BEAT_OFF_W];

  assign mem_ar_valid_o = (state_q == REQ);
  assign mem_ar_addr_o  = {look_pc_q[63:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
  assign mem_r_ready_o  = (state_q == FILL);

  assign fill_fire   = mem_r_ready_o && mem_r_valid_i;
  assign fill_done   = fill_fire && mem_r_last_i;
  assign fill_beat_o = beat_q;
  assign fill_data_o = mem_r_data_i;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      fill_we_o[w] = fill_fire && (victim_q[fill_index_o] == VW'(w));
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (lookup_en_o) state_d = LOOKUP;
      end
      LOOKUP: begin
        if (redirect_valid_i) begin
          state_d = IDLE;
        end else if (!any_hit) begin
          state_d = REQ;
        end else if (inst_ready_i) begin
          state_d = lookup_en_o ? LOOKUP : IDLE;
        end
      end
      REQ: begin
        if (mem_ar_ready_i) state_d = FILL;
      end
      FILL: begin
        // burst cannot be cut short, only its instruction is dropped
        if (fill_done) state_d = (drop_q || redirect_valid_i) ? IDLE : DELIVER;
      end
      DELIVER: begin
        if (redirect_valid_i) begin
          state_d = IDLE;
        end else if (inst_ready_i) begin
          state_d = lookup_en_o ? LOOKUP : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      drop_q  <= 1'b0;
      for (int s = 0; s < NUM_SETS; s++) begin
        victim_q[s] <= '0;
      end
    end else begin
      state_q <= state_d;
      if (state_q == LOOKUP && state_d == REQ) begin
        beat_q <= '0;
        drop_q <= 1'b0;
      end else begin
        if (fill_fire) beat_q <= beat_q + 1'b1;
        if (redirect_valid_i && (state_q == REQ || state_q == FILL)) drop_q <= 1'b1;
      end
      if (fill_done) begin
        victim_q[fill_index_o] <= (victim_q[fill_index_o] == VW'(NUM_WAYS - 1)) ?
                                  '0 : victim_q[fill_index_o] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_en_o) look_pc_q <= req_pc_i;
    if (fill_fire && beat_q == want_beat) begin
      miss_inst_q <= look_pc_q[BEAT_OFF_W-1] ? mem_r_data_i[63:32] : mem_r_data_i[31:0];
    end
  end

  a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
    state_q == LOOKUP |-> $onehot0(hit_i))
    else $error("more than one way hit for pc %h", look_pc_q);

  a_inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o && !inst_ready_i |=> inst_valid_o || redirect_valid_i)
    else $error("inst_valid_o dropped before accept");

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o))
    else $error("mem_ar_valid_o dropped before accept");

  // error responses are not handled, the refill data is taken as is
  a_resp_okay: assert property (@(posedge clk) disable iff (!rst_n)
    fill_fire |-> mem_r_resp_i == RESP_OKAY)
    else $error("refill beat with response %b", mem_r_resp_i);

endmodule

/* logic/icache_way.sv */
`timescale 1ns/10ps

module icache_way
  import fetch_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter  int NUM_SETS = 16,
  localparam int IDX_W    = $clog2(NUM_SETS),
  localparam int TAG_W    = 64 - LINE_OFF_W - IDX_W
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             lookup_en_i,
  input  addr_t            lookup_pc_i,
  output logic             hit_o,
  output inst_t            rdata_o,
  input  logic             fill_we_i,
  input  logic [IDX_W-1:0] fill_index_i,
  input  logic [TAG_W-1:0] fill_tag_i,
  input  beat_t            fill_beat_i,
  input  bus_data_t        fill_data_i
);

  logic [NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q  [NUM_SETS];
  bus_data_t           line_q [NUM_SETS][LINE_BEATS];

  logic [IDX_W-1:0] lk_index;
  logic [TAG_W-1:0] lk_tag;
  beat_t            lk_beat;
  logic             lk_upper;
  bus_data_t        lk_data;
  logic             fill_last;
  logic             hit_q;
  inst_t            rdata_q;

  // split the lookup address
  assign lk_index = lookup_pc_i[LINE_OFF_W +: IDX_W];
  assign lk_tag   = lookup_pc_i[63 -: TAG_W];
  assign lk_beat  = lookup_pc_i[LINE_OFF_W-1:BEAT_OFF_W];
  assign lk_upper = lookup_pc_i[BEAT_OFF_W-1];  // upper word of the beat
  assign lk_data  = line_q[lk_index][lk_beat];

  assign fill_last = fill_we_i && (fill_beat_i == beat_t'(LINE_BEATS - 1));

  // valid only after the whole line has landed
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      hit_q   <= 1'b0;
    end else begin
      if (fill_last) begin
        valid_q[fill_index_i] <= 1'b1;
      end
      if (lookup_en_i) begin
        hit_q <= valid_q[lk_index] && (tag_q[lk_index] == lk_tag);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_we_i) begin
      line_q[fill_index_i][fill_beat_i] <= fill_data_i;
    end
    if (fill_last) begin
      tag_q[fill_index_i] <= fill_tag_i;
    end
    if (lookup_en_i) begin
      rdata_q <= lk_upper ? lk_data[63:32] : lk_data[31:0];
    end
  end

  // both hold until the next lookup
  assign hit_o   = hit_q;
  assign rdata_o = rdata_q;

endmodule

/* logic/if_stage.sv */
`timescale 1ns/10ps

module if_stage
  import fetch_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int    NUM_WAYS = 2,
  parameter int    NUM_SETS = 16,
  parameter addr_t BOOT_PC  = 64'h0000_0000_8000_0000
) (
  input  logic      clk,
  input  logic      rst_n,
  // core side
  output logic      inst_valid_o,
  input  logic      inst_ready_i,
  output inst_t     inst_o,
  output addr_t     inst_pc_o,
  input  logic      redirect_valid_i,
  input  addr_t     redirect_pc_i,
  // memory read channel
  output logic      mem_ar_valid_o,
  input  logic      mem_ar_ready_i,
  output addr_t     mem_ar_addr_o,
  input  logic      mem_r_valid_i,
  output logic      mem_r_ready_o,
  input  bus_data_t mem_r_data_i,
  input  resp_t     mem_r_resp_i,
  input  logic      mem_r_last_i
);

  localparam int IDX_W = $clog2(NUM_SETS);
  localparam int TAG_W = 64 - LINE_OFF_W - IDX_W;

  logic                req_valid;
  logic                req_ready;
  addr_t               req_pc;
  logic                lookup_en;
  logic [NUM_WAYS-1:0] way_hit;
  inst_t               way_rdata [NUM_WAYS];
  logic [NUM_WAYS-1:0] fill_we;
  logic [IDX_W-1:0]    fill_index;
  logic [TAG_W-1:0]    fill_tag;
  beat_t               fill_beat;
  bus_data_t           fill_data;

  fetch_pc_gen #(
    .BOOT_PC (BOOT_PC)
  ) u_pc_gen (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req_ready_i      (req_ready),
    .req_valid_o      (req_valid),
    .req_pc_o         (req_pc)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    icache_way #(
      .NUM_SETS (NUM_SETS)
    ) u_way (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookup_en_i  (lookup_en),
      .lookup_pc_i  (req_pc),
      .hit_o        (way_hit[w]),
      .rdata_o      (way_rdata[w]),
      .fill_we_i    (fill_we[w]),
      .fill_index_i (fill_index),
      .fill_tag_i   (fill_tag),
      .fill_beat_i  (fill_beat),
      .fill_data_i  (fill_data)
    );
  end

  icache_refill_ctrl #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_refill (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_valid_i      (req_valid),
    .req_pc_i         (req_pc),
    .req_ready_o      (req_ready),
    .lookup_en_o      (lookup_en),
    .hit_i            (way_hit),
    .rdata_i          (way_rdata),
    .fill_we_o        (fill_we),
    .fill_index_o     (fill_index),
    .fill_tag_o       (fill_tag),
    .fill_beat_o      (fill_beat),
    .fill_data_o      (fill_data),
    .redirect_valid_i (redirect_valid_i),
    .inst_valid_o     (inst_valid_o),
    .inst_ready_i     (inst_ready_i),
    .inst_o           (inst_o),
    .inst_pc_o        (inst_pc_o),
    .mem_ar_valid_o   (mem_ar_valid_o),
    .mem_ar_ready_i   (mem_ar_ready_i),
    .mem_ar_addr_o    (mem_ar_addr_o),
    .mem_r_valid_i    (mem_r_valid_i),
    .mem_r_ready_o    (mem_r_ready_o),
    .mem_r_data_i     (mem_r_data_i),
    .mem_r_resp_i     (mem_r_resp_i),
    .mem_r_last_i     (mem_r_last_i)
  );

endmodule

/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

  typedef logic [63:0] bus_data_t;  // one read beat
  typedef logic [1:0]  beat_t;      // beat index within a line
  typedef logic [1:0]  resp_t;      // read response code

  // fixed by the bus, a line is one 4-beat burst
  localparam int LINE_BEATS = 4;
  localparam int BEAT_OFF_W = 3;               // 8 bytes per beat
  localparam int LINE_OFF_W = BEAT_OFF_W + 2;  // 32 bytes per line

  localparam resp_t RESP_OKAY = 2'b00;

  // refill controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REQ,
    FILL,
    DELIVER
  } refill_state_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the instruction fetch testbench with verilator
# exit status is the simulator's own

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_if_stage \
  --Mdir obj_dir \
  && ./obj_dir/Vtb_if_stage \
  || exit $?

/* testbench/tb_if_stage.sv */
`timescale 1ns/10ps

module tb_if_stage
  import fetch_pkg::*;
  import mem_bus_pkg::*;
();

  localparam addr_t       BOOT_PC    = 64'h0000_0000_8000_0000;
  localparam int          MAX_CYCLES = 3000;
  localparam logic [31:0] WORD_KEY   = 32'h1357_9BDF;

  logic      clk;
  logic      rst_n;
  logic      inst_valid_o;
  logic      inst_ready_i = 1'b0;
  inst_t     inst_o;
  addr_t     inst_pc_o;
  logic      redirect_valid_i;
  addr_t     redirect_pc_i;
  logic      mem_ar_valid_o;
  logic      mem_ar_ready_i;
  addr_t     mem_ar_addr_o;
  logic      mem_r_valid_i;
  logic      mem_r_ready_o;
  bus_data_t mem_r_data_i;
  resp_t     mem_r_resp_i;
  logic      mem_r_last_i;

  logic        hold_ready;  // ready tied high instead of random
  addr_t       exp_pc;      // pc the core should accept next
  addr_t       seq_pc;
  inst_t       exp_inst;
  logic [31:0] line_seen;   // lines of the 1 KiB test region requested so far
  logic        inst_fire;
  logic        next_cached;
  int          accepted;
  int          cycle_cnt;

  if_stage if_stage_i (
    .clk (clk), .rst_n (rst_n),
    .inst_valid_o (inst_valid_o), .inst_ready_i (inst_ready_i),
    .inst_o (inst_o), .inst_pc_o (inst_pc_o),
    .redirect_valid_i (redirect_valid_i), .redirect_pc_i (redirect_pc_i),
    .mem_ar_valid_o (mem_ar_valid_o), .mem_ar_ready_i (mem_ar_ready_i),
    .mem_ar_addr_o (mem_ar_addr_o), .mem_r_valid_i (mem_r_valid_i),
    .mem_r_ready_o (mem_r_ready_o), .mem_r_data_i (mem_r_data_i),
    .mem_r_resp_i (mem_r_resp_i), .mem_r_last_i (mem_r_last_i)
  );

  tb_mem_model u_mem (
    .clk (clk), .rst_n (rst_n),
    .ar_valid_i (mem_ar_valid_o), .ar_ready_o (mem_ar_ready_i), .ar_addr_i (mem_ar_addr_o),
    .r_valid_o (mem_r_valid_i), .r_ready_i (mem_r_ready_o), .r_data_o (mem_r_data_i),
    .r_resp_o (mem_r_resp_i), .r_last_o (mem_r_last_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  function automatic inst_t expected_word(input addr_t a);
    return a[31:0] ^ WORD_KEY;
  endfunction

  assign inst_fire   = inst_valid_o && inst_ready_i;
  assign seq_pc      = exp_pc + 64'd4;
  assign exp_inst    = expected_word(exp_pc);
  assign next_cached = line_seen[seq_pc[9:5]] && (seq_pc[63:10] == BOOT_PC[63:10]);

  // reference model of the fetch path
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc    <= BOOT_PC;
      line_seen <= '0;
      accepted  <= 0;
    end else begin
      if (redirect_valid_i) begin
        exp_pc <= redirect_pc_i;
      end else if (inst_fire) begin
        exp_pc <= seq_pc;
      end
      if (inst_fire) accepted <= accepted + 1;
      if (mem_ar_valid_o && mem_ar_ready_i) line_seen[mem_ar_addr_o[9:5]] <= 1'b1;
    end
  end

  always @(posedge clk) begin
    inst_ready_i <= hold_ready || ($urandom_range(3) != 0);  // low about 1 in 4
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) abort_run("timeout: fetch stimulus did not complete in time");
  end

  a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
    inst_fire |-> inst_pc_o == exp_pc)
    else abort_run($sformatf("ERR %0t: accepted pc %h, expected %h",
                             $time, $sampled(inst_pc_o), $sampled(exp_pc)));

  a_inst_data: assert property (@(posedge clk) disable iff (!rst_n)
    inst_fire |-> inst_o == exp_inst)
    else abort_run($sformatf("ERR %0t: instruction %h at pc %h, expected %h",
                             $time, $sampled(inst_o), $sampled(exp_pc), $sampled(exp_inst)));

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o && !inst_ready_i |=>
      redirect_valid_i || (inst_valid_o && $stable(inst_o) && $stable(inst_pc_o)))
    else abort_run($sformatf("ERR %0t: output changed while stalled", $time));

  // idle output carries the addi x0 no-op
  a_idle_nop: assert property (@(posedge clk) disable iff (!rst_n)
    !inst_valid_o |-> inst_o == NOP_INST)
    else abort_run($sformatf("ERR %0t: inst_o %h while not valid", $time, $sampled(inst_o)));

  a_ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid_o |-> mem_ar_addr_o[4:0] == 5'd0 && mem_ar_addr_o[63:10] == BOOT_PC[63:10])
    else abort_run($sformatf("ERR %0t: bad refill address %h", $time, $sampled(mem_ar_addr_o)));

  // no eviction in this test, so a cached line is never read twice
  a_ar_once: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid_o && mem_ar_ready_i |-> !line_seen[mem_ar_addr_o[9:5]])
    else abort_run($sformatf("ERR %0t: line %h refilled again", $time, $sampled(mem_ar_addr_o)));

  a_hit_stream: assert property (@(posedge clk) disable iff (!rst_n)
    inst_fire && next_cached |=> inst_valid_o || redirect_valid_i)
    else abort_run($sformatf("ERR %0t: bubble after pc %h on a cached line",
                             $time, $sampled(exp_pc)));

  task automatic wait_accepts(input int count);
    int target;
    target = accepted + count;
    while (accepted < target) @(posedge clk);
  endtask

  task automatic redirect_to(input addr_t target);
    @(posedge clk);
    redirect_valid_i <= 1'b1;
    redirect_pc_i    <= target;
    @(posedge clk);
    redirect_valid_i <= 1'b0;
  endtask

  initial begin
    void'($urandom(76144));
    rst_n            = 1'b0;
    hold_ready       = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (!inst_valid_o && !mem_ar_valid_o && !mem_r_ready_o)
      else abort_run($sformatf("ERR %0t: fetch outputs active after reset", $time));

    wait_accepts(40);                  // five lines sequential from boot
    redirect_to(BOOT_PC + 64'h200);    // jump forward into the second line of set 0
    wait_accepts(24);
    hold_ready <= 1'b1;
    redirect_to(BOOT_PC + 64'h40);     // back into cached lines
    wait_accepts(16);
    hold_ready <= 1'b0;
    redirect_to(BOOT_PC + 64'h314);    // target in the middle of a line
    wait_accepts(20);
    while (!mem_r_ready_o) @(posedge clk);
    redirect_to(BOOT_PC + 64'h8);      // redirect while a burst is running
    wait_accepts(12);
    repeat (4) @(posedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/10ps

module tb_mem_model
  import fetch_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  input  addr_t     ar_addr_i,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output bus_data_t r_data_o,
  output resp_t     r_resp_o,
  output logic      r_last_o
);

  localparam logic [31:0] WORD_KEY = 32'h1357_9BDF;

  addr_t line_addr;  // line of the burst being returned
  int    beat_idx;
  int    delay;      // wait states before ar_ready
  int    gap;        // idle cycles before the next beat
  logic  streaming;

  // every word is derived from its own byte address
  function automatic inst_t word_at(input addr_t a);
    return a[31:0] ^ WORD_KEY;
  endfunction

  function automatic bus_data_t beat_at(input addr_t a);
    return {word_at(a + 64'd4), word_at(a)};  // lower address in the low half
  endfunction

  assign r_resp_o = RESP_OKAY;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      r_data_o   <= '0;
      r_last_o   <= 1'b0;
      line_addr  <= '0;
      beat_idx   <= 0;
      delay      <= 0;
      gap        <= 0;
      streaming  <= 1'b0;
    end else if (!streaming) begin
      if (ar_valid_i && ar_ready_o) begin
        ar_ready_o <= 1'b0;
        line_addr  <= ar_addr_i;
        beat_idx   <= 0;
        gap        <= $urandom_range(0, 2);
        streaming  <= 1'b1;
      end else if (ar_valid_i) begin
        if (delay == 0) ar_ready_o <= 1'b1;
        else delay <= delay - 1;
      end
    end else if (r_valid_o) begin
      if (r_ready_i) begin
        r_valid_o <= 1'b0;
        r_last_o  <= 1'b0;
        beat_idx  <= beat_idx + 1;
        gap       <= $urandom_range(0, 2);
        if (r_last_o) begin
          streaming <= 1'b0;
          delay     <= $urandom_range(0, 3);
        end
      end
    end else if (gap == 0) begin
      r_valid_o <= 1'b1;
      r_data_o  <= beat_at(line_addr + addr_t'(8 * beat_idx));
      r_last_o  <= (beat_idx == LINE_BEATS - 1);
    end else begin
      gap <= gap - 1;  // random stall between beats
    end
  end

endmodule
